//--- src/rv_isa_pkg.sv
/*
 * RV32I encoding constants: opcode groups, fn3 and fn7 codes,
 * register port indices and the base instruction field layout
 */
package rv_isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // Opcode groups (instr[6:0])
    //////////////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    // OP-IMM group
    localparam logic [6:0] OPC_ARITH_IMM = 7'b0010011;
    // OP group
    localparam logic [6:0] OPC_ARITH_REG = 7'b0110011;

    //////////////////////////////////////////////////////////////////////
    // fn3 codes of the arithmetic groups
    //////////////////////////////////////////////////////////////////////
    localparam logic [2:0] FN3_ADD_SUB = 3'b000;
    localparam logic [2:0] FN3_SLL     = 3'b001;
    localparam logic [2:0] FN3_SLT     = 3'b010;
    localparam logic [2:0] FN3_SLTU    = 3'b011;
    localparam logic [2:0] FN3_XOR     = 3'b100;
    localparam logic [2:0] FN3_SRL_SRA = 3'b101;
    localparam logic [2:0] FN3_OR      = 3'b110;
    localparam logic [2:0] FN3_AND     = 3'b111;

    // JALR only exists with fn3 zero
    localparam logic [2:0] FN3_JALR    = 3'b000;

    //////////////////////////////////////////////////////////////////////
    // fn7 codes
    //////////////////////////////////////////////////////////////////////
    // Normal form
    localparam logic [6:0] FN7_BASE = 7'b0000000;
    // SUB and SRA/SRAI, only bit 30 set
    localparam logic [6:0] FN7_ALT  = 7'b0100000;

    // Bit positions in the uses_rs vector
    localparam int RS1 = 0;
    localparam int RS2 = 1;

    //////////////////////////////////////////////////////////////////////
    // R-type field layout
    //////////////////////////////////////////////////////////////////////
    // I-type immediate overlays fn7 and rs2
    // U-type immediate overlays fn7 down to fn3
    typedef struct packed {
        logic [6:0] fn7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] fn3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_instr_t;

endpackage

//--- src/alu_types_pkg.sv
/*
 * ALU path types: micro-op enum, incoming instruction packet,
 * issue packet and writeback packet
 */
package alu_types_pkg;

    // Tag width, identifies an instruction through the path
    localparam int TAG_W = 4;

    // Result source in the execute stage
    typedef enum logic [1:0] {
        ALU_CONSTANT = 2'd0,
        ALU_ADD_SUB  = 2'd1,
        ALU_SLT      = 2'd2,
        ALU_SHIFT    = 2'd3
    } alu_op_t;

    // Instruction with operands already read
    typedef struct packed {
        logic [31:0]      instr;
        logic [31:0]      rs1_data;
        logic [31:0]      rs2_data;
        logic [31:0]      pc;
        logic [TAG_W-1:0] tag;
    } alu_in_t;

    // Decoded micro-op, held in the issue FIFO
    typedef struct packed {
        alu_op_t          op;
        logic             subtract;
        logic             imm_type;
        logic             arith_shift;
        logic [2:0]       fn3;
        // rs1 data
        logic [31:0]      a;
        // Sign-extended I immediate or rs2 data
        logic [31:0]      b;
        logic [4:0]       shamt;
        // LUI imm, PC + AUIPC imm, or PC+4
        logic [31:0]      constant;
        logic [TAG_W-1:0] tag;
        logic [4:0]       rd;
    } alu_issue_t;

    // Writeback packet
    typedef struct packed {
        logic [31:0]      result;
        logic [TAG_W-1:0] tag;
        logic [4:0]       rd;
    } alu_wb_t;

endpackage

//--- src/barrel_shifter.sv
/*
 * 32-bit barrel shifter built on one right-shift array for all kinds
 */
`timescale 1ns/1ps

module barrel_shifter (
    input  logic [31:0] shift_in,
    input  logic [4:0]  shamt,
    input  logic        arith,
    input  logic        left,
    output logic [31:0] shift_out
);

    logic [31:0] rev_in;
    logic [31:0] pre;
    logic [31:0] shifted;
    logic [31:0] rev_out;
    logic        fill;

    // Left shifts run through the right shifter bit-reversed
    assign rev_in = {<<{shift_in}};
    assign pre    = left ? rev_in : shift_in;

    // Sign fill only for arithmetic right shifts
    assign fill = arith & ~left & shift_in[31];

    // 33-bit signed shift with the fill value in the extra bit
    always_comb begin
        logic [32:0] wide;
        wide    = 33'($signed({fill, pre}) >>> shamt);
        shifted = wide[31:0];
    end

    // Undo the reversal
    assign rev_out   = {<<{shifted}};
    assign shift_out = left ? rev_out : shifted;

endmodule

//--- src/alu_issue_fifo.sv
/*
 * Synchronous circular FIFO with a type parameter for the payload
 */
`timescale 1ns/1ps

module alu_issue_fifo #(
    parameter int  DEPTH = 4,
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     push,
    input  payload_t wr_data,
    input  logic     pop,
    output payload_t rd_data,

    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////
    // Wrap at DEPTH-1, depth need not be a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10   : count <= count + 1'b1;
                2'b01   : count <= count - 1'b1;
                default : count <= count;
            endcase
        end
    end

    // Head of queue
    assign rd_data = mem[rd_ptr];

    assign full  = count == CNT_W'(DEPTH);
    assign empty = count == '0;

endmodule

//--- src/alu_decoder.sv
/*
 * ALU decoder: classifies an RV32I instruction, builds the issue
 * packet with immediates and constant result, and pushes it
 */
`timescale 1ns/1ps

module alu_decoder
    import rv_isa_pkg::*;
    import alu_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       in_valid,
    input  alu_in_t    in_pkt,
    input  logic       fifo_full,

    output logic       push,
    output alu_issue_t push_pkt,
    output logic       reject,

    output logic [1:0] uses_rs,
    output logic       uses_rd
);

    rv_instr_t   instr;
    logic        is_lui;
    logic        is_auipc;
    logic        is_jal;
    logic        is_jalr;
    logic        is_imm;
    logic        is_reg;
    logic        is_upper;
    logic        is_alu;
    logic        imm_ok;
    logic        reg_ok;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    alu_op_t     op;
    logic [31:0] constant;

    //////////////////////////////////////////////////////////////////////
    // Classification
    //////////////////////////////////////////////////////////////////////
    assign instr = rv_instr_t'(in_pkt.instr);

    assign is_lui   = instr.opcode == OPC_LUI;
    assign is_auipc = instr.opcode == OPC_AUIPC;
    assign is_jal   = instr.opcode == OPC_JAL;
    assign is_jalr  = (instr.opcode == OPC_JALR) && (instr.fn3 == FN3_JALR);
    assign is_imm   = instr.opcode == OPC_ARITH_IMM;
    assign is_reg   = instr.opcode == OPC_ARITH_REG;
    assign is_upper = is_lui | is_auipc | is_jal | is_jalr;

    // Immediate shifts constrain fn7, all other OP-IMM forms take any imm
    always_comb begin
        case (instr.fn3)
            FN3_SLL     : imm_ok = instr.fn7 == FN7_BASE;
            FN3_SRL_SRA : imm_ok = instr.fn7 inside {FN7_BASE, FN7_ALT};
            default     : imm_ok = 1'b1;
        endcase
    end

    // Alternate fn7 only for SUB and SRA
    assign reg_ok = (instr.fn7 == FN7_BASE) ||
                    ((instr.fn7 == FN7_ALT) && (instr.fn3 inside {FN3_ADD_SUB, FN3_SRL_SRA}));

    assign is_alu = is_upper | (is_imm & imm_ok) | (is_reg & reg_ok);

    // Operand usage of the current packet, for the scoreboard
    always_comb begin
        uses_rs      = '0;
        uses_rs[RS1] = is_jalr | (is_imm & imm_ok) | (is_reg & reg_ok);
        uses_rs[RS2] = is_reg & reg_ok;
        uses_rd      = is_alu;
    end

    //////////////////////////////////////////////////////////////////////
    // Op select and immediates
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        if (is_upper) begin
            op = ALU_CONSTANT;
        end else begin
            case (instr.fn3)
                FN3_SLT, FN3_SLTU    : op = ALU_SLT;
                FN3_SLL, FN3_SRL_SRA : op = ALU_SHIFT;
                default              : op = ALU_ADD_SUB;
            endcase
        end
    end

    // I immediate: fn7 and rs2 fields, sign-extended
    assign imm_i = {{20{instr.fn7[6]}}, instr.fn7, instr.rs2};
    // U immediate: upper 20 bits, low half zero
    assign imm_u = {in_pkt.instr[31:12], 12'b0};

    // Constant path: LUI, AUIPC, link value for JAL/JALR
    always_comb begin
        if (is_lui) begin
            constant = imm_u;
        end else if (is_auipc) begin
            constant = in_pkt.pc + imm_u;
        end else begin
            constant = in_pkt.pc + 32'd4;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Issue packet
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        push_pkt.op          = op;
        push_pkt.imm_type    = is_imm;
        // SUB and both compares subtract
        push_pkt.subtract    = ~is_upper &
                               ((instr.fn3 inside {FN3_SLT, FN3_SLTU}) |
                                (is_reg & (instr.fn3 == FN3_ADD_SUB) & instr.fn7[5]));
        push_pkt.arith_shift = (instr.fn3 == FN3_SRL_SRA) & instr.fn7[5];
        push_pkt.fn3         = instr.fn3;
        push_pkt.a           = in_pkt.rs1_data;
        push_pkt.b           = is_imm ? imm_i : in_pkt.rs2_data;
        // Shift amount from rs2 field or rs2 data
        push_pkt.shamt       = is_imm ? instr.rs2 : in_pkt.rs2_data[4:0];
        push_pkt.constant    = constant;
        push_pkt.tag         = in_pkt.tag;
        push_pkt.rd          = instr.rd;
    end

    // Only the decoder checks for a full FIFO
    assign push = in_valid & is_alu & ~fifo_full;

    // Unsupported or dropped instruction, one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reject <= 1'b0;
        end else begin
            reject <= in_valid & (~is_alu | fifo_full);
        end
    end

endmodule

//--- src/alu_execute.sv
/*
 * ALU execute stage: pops issue packets, computes add/sub, logic,
 * compare and shift results and registers the writeback packet
 */
`timescale 1ns/1ps

module alu_execute
    import rv_isa_pkg::*;
    import alu_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       empty,
    input  alu_issue_t head,
    input  logic       wb_stall,
    output logic       pop,

    output logic       wb_valid,
    output alu_wb_t    wb_pkt
);

    logic [31:0] pre_a;
    logic [31:0] pre_b;
    logic        unsigned_cmp;
    logic [32:0] ext_a;
    logic [32:0] ext_b;
    logic [33:0] sum_full;
    logic [32:0] sum;
    logic [31:0] shift_out;
    logic [31:0] result;

    // Pop whenever there is work and writeback is free
    assign pop = ~empty & ~wb_stall;

    //////////////////////////////////////////////////////////////////////
    // Adder datapath
    //////////////////////////////////////////////////////////////////////
    // Logic ops combined up front, result passes the adder with b zeroed
    always_comb begin
        case (head.fn3)
            FN3_XOR : pre_a = head.a ^ head.b;
            FN3_OR  : pre_a = head.a | head.b;
            FN3_AND : pre_a = head.a & head.b;
            default : pre_a = head.a;
        endcase
        case (head.fn3)
            FN3_XOR,
            FN3_OR,
            FN3_AND : pre_b = '0;
            default : pre_b = head.b ^ {32{head.subtract}};
        endcase
    end

    // Zero extension for SLTU, sign extension otherwise
    assign unsigned_cmp = head.fn3 == FN3_SLTU;

    assign ext_a = {head.a[31] & ~unsigned_cmp, pre_a};
    assign ext_b = {(head.b[31] & ~unsigned_cmp) ^ head.subtract, pre_b};

    // Carry-in for subtract rides in the extra low bit
    assign sum_full = {ext_a, 1'b1} + {ext_b, head.subtract};
    assign sum      = sum_full[33:1];

    //////////////////////////////////////////////////////////////////////
    // Shifter
    //////////////////////////////////////////////////////////////////////
    // SLL has fn3[2] clear, SRL/SRA set
    barrel_shifter shifter (
        .shift_in  (head.a),
        .shamt     (head.shamt),
        .arith     (head.arith_shift),
        .left      (~head.fn3[2]),
        .shift_out (shift_out)
    );

    //////////////////////////////////////////////////////////////////////
    // Result select and writeback
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (head.op)
            ALU_CONSTANT : result = head.constant;
            ALU_ADD_SUB  : result = sum[31:0];
            // Sign of the 33-bit difference is the less-than flag
            ALU_SLT      : result = {31'b0, sum[32]};
            default      : result = shift_out;
        endcase
    end

    // Valid pulse follows every pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= pop;
        end
    end

    // Payload only loads on a pop
    always_ff @(posedge clk) begin
        if (pop) begin
            wb_pkt.result <= result;
            wb_pkt.tag    <= head.tag;
            wb_pkt.rd     <= head.rd;
        end
    end

endmodule

//--- src/alu_subsystem_top.sv
/*
 * ALU path top level: decoder, issue FIFO and execute stage
 */
`timescale 1ns/1ps

module alu_subsystem_top
    import alu_types_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       in_valid,
    input  alu_in_t    in_pkt,
    input  logic       wb_stall,

    output logic       fifo_full,
    output logic       reject,
    output logic [1:0] uses_rs,
    output logic       uses_rd,

    output logic       wb_valid,
    output alu_wb_t    wb_pkt
);

    // Decoder to FIFO
    logic       push;
    alu_issue_t push_pkt;

    // FIFO to execute
    logic       pop;
    logic       empty;
    alu_issue_t head;

    alu_decoder decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pkt    (in_pkt),
        .fifo_full (fifo_full),
        .push      (push),
        .push_pkt  (push_pkt),
        .reject    (reject),
        .uses_rs   (uses_rs),
        .uses_rd   (uses_rd)
    );

    // Holds packets while writeback stalls
    alu_issue_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (alu_issue_t)
    ) issue_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (push),
        .wr_data (push_pkt),
        .pop     (pop),
        .rd_data (head),
        .full    (fifo_full),
        .empty   (empty)
    );

    alu_execute execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .empty    (empty),
        .head     (head),
        .wb_stall (wb_stall),
        .pop      (pop),
        .wb_valid (wb_valid),
        .wb_pkt   (wb_pkt)
    );

endmodule

//--- verification/alu_model.svh
/*
 * Reference model: ALU instruction classification, operand usage
 * and RV32I result evaluation
 */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Legal ALU-path instruction per the RV32I encoding
function automatic logic alu_instr_ok(input logic [31:0] ins);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    case (opc)
        OPC_LUI, OPC_AUIPC, OPC_JAL : return 1'b1;
        OPC_JALR : return f3 == 3'b000;
        OPC_ARITH_IMM : begin
            // SLLI, SRLI and SRAI reserve the top immediate bits
            if (f3 == 3'b001) return f7 == 7'h00;
            if (f3 == 3'b101) return (f7 == 7'h00) || (f7 == 7'h20);
            return 1'b1;
        end
        OPC_ARITH_REG : begin
            if (f7 == 7'h00) return 1'b1;
            return (f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101));
        end
        default : return 1'b0;
    endcase
endfunction

// Register usage as {rd, rs2, rs1}
function automatic logic [2:0] operand_usage(input logic [31:0] ins);
    if (!alu_instr_ok(ins)) return 3'b000;
    case (ins[6:0])
        OPC_ARITH_REG          : return 3'b111;
        OPC_ARITH_IMM, OPC_JALR : return 3'b101;
        default                : return 3'b100;
    endcase
endfunction

// Result as the ISA defines it
function automatic logic [31:0] isa_result(input logic [31:0] ins, input logic [31:0] rs1,
                                           input logic [31:0] rs2, input logic [31:0] pc);
    logic [31:0] b;
    logic [4:0]  sh;
    logic        is_reg;
    is_reg = ins[6:0] == OPC_ARITH_REG;
    case (ins[6:0])
        OPC_LUI            : return {ins[31:12], 12'b0};
        OPC_AUIPC          : return pc + {ins[31:12], 12'b0};
        OPC_JAL, OPC_JALR  : return pc + 32'd4;
        default            : ;
    endcase
    // Second operand is the I immediate or rs2
    b  = is_reg ? rs2 : {{20{ins[31]}}, ins[31:20]};
    sh = is_reg ? rs2[4:0] : ins[24:20];
    case (ins[14:12])
        3'b000  : return (is_reg && ins[30]) ? rs1 - b : rs1 + b;
        3'b001  : return rs1 << sh;
        3'b010  : return ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011  : return (rs1 < b) ? 32'd1 : 32'd0;
        3'b100  : return rs1 ^ b;
        3'b101  : return ins[30] ? 32'($signed(rs1) >>> sh) : rs1 >> sh;
        3'b110  : return rs1 | b;
        default : return rs1 & b;
    endcase
endfunction

`endif

//--- verification/alu_tb.sv
/*
 * Testbench for the ALU path: random stimulus, scoreboard queue
 * against the reference model, stall and latency tests
 */
`timescale 1ns/1ps

module alu_tb
    import rv_isa_pkg::*;
    import alu_types_pkg::*;
;

    localparam int FIFO_DEPTH = 4;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    alu_in_t    in_pkt;
    logic       wb_stall;
    logic       fifo_full;
    logic       reject;
    logic [1:0] uses_rs;
    logic       uses_rd;
    logic       wb_valid;
    alu_wb_t    wb_pkt;

    // Scoreboard state
    alu_wb_t          exp_q[$];
    alu_wb_t          exp_wb;
    logic             exp_reject;
    integer           seed;
    logic [TAG_W-1:0] next_tag;
    int               err_count;
    int               n_checks;
    int               tests_run;
    int               tests_failed;
    logic             timed_out;

    `include "alu_model.svh"

    alu_subsystem_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pkt    (in_pkt),
        .wb_stall  (wb_stall),
        .fifo_full (fifo_full),
        .reject    (reject),
        .uses_rs   (uses_rs),
        .uses_rd   (uses_rd),
        .wb_valid  (wb_valid),
        .wb_pkt    (wb_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus generators
    //////////////////////////////////////////////////////////////////////
    // Signed and unsigned boundaries mixed with random values
    function automatic logic [31:0] boundary_operand();
        logic [31:0] r;
        logic [31:0] sel;
        r   = $random(seed);
        sel = $random(seed);
        case (sel[2:0])
            3'd0    : return 32'h0000_0000;
            3'd1    : return 32'h0000_0001;
            3'd2    : return 32'h7fff_ffff;
            3'd3    : return 32'h8000_0000;
            3'd4    : return 32'hffff_ffff;
            default : return r;
        endcase
    endfunction

    function automatic logic [31:0] reg_instr();
        logic [31:0] r;
        logic [6:0]  f7;
        r  = $random(seed);
        f7 = (r[30] && (r[14:12] inside {FN3_ADD_SUB, FN3_SRL_SRA})) ? FN7_ALT : FN7_BASE;
        return {f7, r[24:7], OPC_ARITH_REG};
    endfunction

    function automatic logic [31:0] imm_instr();
        logic [31:0] r;
        logic [6:0]  hi;
        r = $random(seed);
        if (r[14:12] == FN3_SLL) hi = FN7_BASE;
        else if (r[14:12] == FN3_SRL_SRA) hi = r[30] ? FN7_ALT : FN7_BASE;
        else hi = r[31:25];
        return {hi, r[24:7], OPC_ARITH_IMM};
    endfunction

    // LUI, AUIPC, JAL or JALR
    function automatic logic [31:0] upper_instr();
        logic [31:0] r;
        r = $random(seed);
        case (r[1:0])
            2'd0    : return {r[31:7], OPC_LUI};
            2'd1    : return {r[31:7], OPC_AUIPC};
            2'd2    : return {r[31:7], OPC_JAL};
            default : return {r[31:15], FN3_JALR, r[11:7], OPC_JALR};
        endcase
    endfunction

    // Loads, stores and branches
    function automatic logic [31:0] non_alu_instr();
        logic [31:0] r;
        r = $random(seed);
        case (r[1:0])
            2'd0    : return {r[31:7], 7'b0000011};
            2'd1    : return {r[31:7], 7'b0100011};
            default : return {r[31:7], 7'b1100011};
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Drivers and waits
    //////////////////////////////////////////////////////////////////////
    task automatic drive_instr(input logic [31:0] ins);
        @(posedge clk);
        #1;
        in_valid        = 1'b1;
        in_pkt.instr    = ins;
        in_pkt.rs1_data = boundary_operand();
        in_pkt.rs2_data = boundary_operand();
        in_pkt.pc       = $random(seed) & 32'hffff_fffc;
        in_pkt.tag      = next_tag;
        next_tag        = next_tag + 1'b1;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Until every expected result has come back
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        drive_idle();
        while (exp_q.size() != 0 && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d results still pending after the drain", exp_q.size());
            err_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count > errs_before) begin
            tests_failed++;
            $display("%-16s FAILED with %0d errors", name, err_count - errs_before);
        end else begin
            $display("%-16s passed", name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitor, sampled at the falling edge
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_reject = 1'b0;
        end else begin
            if (wb_valid) begin
                n_checks++;
                assert (exp_q.size() > 0) else begin
                    $display("Writeback with tag %h arrived with no result expected", wb_pkt.tag);
                    err_count++;
                end
                if (exp_q.size() > 0) begin
                    exp_wb = exp_q.pop_front();
                    assert (wb_pkt.tag == exp_wb.tag) else begin
                        $display("CHECK FAILED wb_pkt.tag: got %h expected %h",
                                 wb_pkt.tag, exp_wb.tag);
                        err_count++;
                    end
                    assert (wb_pkt.rd == exp_wb.rd) else begin
                        $display("CHECK FAILED wb_pkt.rd: got %h expected %h",
                                 wb_pkt.rd, exp_wb.rd);
                        err_count++;
                    end
                    assert (wb_pkt.result == exp_wb.result) else begin
                        $display("CHECK FAILED wb_pkt.result: got %h expected %h (tag %h)",
                                 wb_pkt.result, exp_wb.result, exp_wb.tag);
                        err_count++;
                    end
                end
            end
            // Reject follows one cycle after a dropped strobe
            n_checks++;
            assert (reject == exp_reject) else begin
                $display("CHECK FAILED reject: got %h expected %h", reject, exp_reject);
                err_count++;
            end
            exp_reject = in_valid & (~alu_instr_ok(in_pkt.instr) | fifo_full);
            if (in_valid) begin
                n_checks++;
                assert ({uses_rd, uses_rs} == operand_usage(in_pkt.instr)) else begin
                    $display("CHECK FAILED uses_rd/uses_rs: got %h expected %h",
                             {uses_rd, uses_rs}, operand_usage(in_pkt.instr));
                    err_count++;
                end
                // Accepted at the coming edge
                if (alu_instr_ok(in_pkt.instr) && !fifo_full) begin
                    exp_wb.result = isa_result(in_pkt.instr, in_pkt.rs1_data,
                                               in_pkt.rs2_data, in_pkt.pc);
                    exp_wb.tag    = in_pkt.tag;
                    exp_wb.rd     = in_pkt.instr[11:7];
                    exp_q.push_back(exp_wb);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////
    task automatic random_alu_ops();
        int          errs_before;
        int          i;
        logic [31:0] r;
        errs_before = err_count;
        for (i = 0; i < 300; i++) begin
            r = $random(seed);
            if (r[3:0] == 4'd0) drive_idle();
            else if (r[4]) drive_instr(reg_instr());
            else drive_instr(imm_instr());
        end
        wait_drain();
        report_test("random_alu_ops", errs_before);
    endtask

    task automatic upper_ops();
        int errs_before;
        int i;
        errs_before = err_count;
        for (i = 0; i < 60; i++) begin
            drive_instr(upper_instr());
        end
        wait_drain();
        report_test("upper_ops", errs_before);
    endtask

    // Mostly rejects, a few ALU ops to check the tag order around them
    task automatic non_alu_ops();
        int          errs_before;
        int          i;
        logic [31:0] r;
        errs_before = err_count;
        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            if (r[1:0] == 2'd0) drive_instr(imm_instr());
            else drive_instr(non_alu_instr());
        end
        wait_drain();
        report_test("non_alu_ops", errs_before);
    endtask

    task automatic stall_burst();
        int errs_before;
        int i;
        int accepted;
        errs_before = err_count;
        wait_drain();
        @(posedge clk);
        #1;
        wb_stall = 1'b1;
        accepted = 0;
        for (i = 0; i < FIFO_DEPTH + 3; i++) begin
            drive_instr(i[0] ? reg_instr() : imm_instr());
            @(negedge clk);
            n_checks++;
            assert (fifo_full == (accepted >= FIFO_DEPTH)) else begin
                $display("CHECK FAILED fifo_full: got %h expected %h",
                         fifo_full, accepted >= FIFO_DEPTH);
                err_count++;
            end
            assert (!wb_valid) else begin
                $display("Writeback issued while wb_stall was high");
                err_count++;
            end
            if (accepted < FIFO_DEPTH) accepted++;
        end
        // Release and let the queue drain in order
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        wb_stall = 1'b0;
        wait_drain();
        report_test("stall_burst", errs_before);
    endtask

    task automatic latency_check();
        int   errs_before;
        int   i;
        int   edges;
        logic seen;
        errs_before = err_count;
        for (i = 0; i < 6 && !timed_out; i++) begin
            wait_drain();
            case (i % 3)
                0       : drive_instr(reg_instr());
                1       : drive_instr(imm_instr());
                default : drive_instr(upper_instr());
            endcase
            // First edge counted is the acceptance edge
            edges = 0;
            seen  = 1'b0;
            while (!seen && edges < 10) begin
                @(posedge clk);
                #1;
                in_valid = 1'b0;
                edges++;
                @(negedge clk);
                seen = wb_valid;
            end
            if (!seen) begin
                $display("Timeout: no writeback for a single instruction");
                err_count++;
                timed_out = 1'b1;
            end else begin
                n_checks++;
                assert (edges == 2) else begin
                    $display("CHECK FAILED latency: got %h expected %h", edges, 2);
                    err_count++;
                end
            end
        end
        if (!timed_out) wait_drain();
        report_test("latency_check", errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        seed         = 32'hd868c63d;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_pkt       = '0;
        wb_stall     = 1'b0;
        next_tag     = '0;
        exp_reject   = 1'b0;
        err_count    = 0;
        n_checks     = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        random_alu_ops();
        if (!timed_out) upper_ops();
        if (!timed_out) non_alu_ops();
        if (!timed_out) stall_burst();
        if (!timed_out) latency_check();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, n_checks, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+verification
src/rv_isa_pkg.sv
src/alu_types_pkg.sv
src/barrel_shifter.sv
src/alu_issue_fifo.sv
src/alu_decoder.sv
src/alu_execute.sv
src/alu_subsystem_top.sv
verification/alu_tb.sv
